// ==== list.f ====
source/board_pkg.sv
source/script_pkg.sv
source/por_reset.sv
source/spi_flash_reader.sv
source/script_sequencer.sv
source/pin_bank.sv
source/board_top.sv
testbench/spi_flash_model.sv
testbench/tb_board_top.sv

// ==== source/board_pkg.sv ====
package board_pkg;

	localparam int pin_width = 32;

	// Bit positions in the output pin register.
	localparam int gpio_base = 0;
	localparam int led_base = 8;
	localparam int dac_base = 11;
	localparam int uart_bit = 15;
	localparam int vga_b_base = 16;
	localparam int vga_r_base = 20;
	localparam int vga_g_base = 24;
	localparam int hs_bit = 28;
	localparam int vs_bit = 29;

	// Up sits in bit 0, as on the input byte of the board.
	typedef struct packed {
		logic b;
		logic a;
		logic right;
		logic left;
		logic down;
		logic up;
	} buttons_t;

	typedef struct packed {
		logic blue;
		logic green;
		logic red;
	} led_t;

	typedef struct packed {
		logic       vs;
		logic       hs;
		logic [3:0] g;
		logic [3:0] r;
		logic [3:0] b;
	} vga_t;

	typedef struct packed {
		logic sdin;
		logic sclk;
		logic lrclk;
		logic mclk;
	} dac_t;

endpackage

// ==== source/board_top.sv ====
module board_top
	import board_pkg::*, script_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  buttons_t   buttons,
	output led_t       leds,
	output vga_t       vga,
	output dac_t       dac,
	output logic       uart_tx,
	output logic [1:0] gpio,
	output logic       flash_cs_n,
	output logic       flash_sck,
	output logic       flash_mosi,
	input  logic       flash_miso
);

	logic                 core_rst_n;
	logic                 fetch_req;
	fetch_req_t           fetch_cmd;
	logic                 fetch_ack;
	logic [7:0]           fetch_data;
	logic                 lane_we;
	logic [1:0]           lane_sel;
	logic [7:0]           lane_data;
	logic [pin_width-1:0] pins;
	buttons_t             buttons_sync;

	por_reset i_por_reset (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n)
	);

	spi_flash_reader i_reader (
		.clk        (clk),
		.rst_n      (core_rst_n),
		.fetch_req  (fetch_req),
		.fetch_cmd  (fetch_cmd),
		.fetch_ack  (fetch_ack),
		.fetch_data (fetch_data),
		.flash_cs_n (flash_cs_n),
		.flash_sck  (flash_sck),
		.flash_mosi (flash_mosi),
		.flash_miso (flash_miso)
	);

	script_sequencer i_sequencer (
		.clk          (clk),
		.rst_n        (core_rst_n),
		.fetch_req    (fetch_req),
		.fetch_cmd    (fetch_cmd),
		.fetch_ack    (fetch_ack),
		.fetch_data   (fetch_data),
		.lane_we      (lane_we),
		.lane_sel     (lane_sel),
		.lane_data    (lane_data),
		.buttons_sync (buttons_sync)
	);

	pin_bank i_pin_bank (
		.clk          (clk),
		.rst_n        (core_rst_n),
		.lane_we      (lane_we),
		.lane_sel     (lane_sel),
		.lane_data    (lane_data),
		.pins         (pins),
		.buttons      (buttons),
		.buttons_sync (buttons_sync)
	);

	// Pin register to board pins. Bits 2 to 7 and 30 to 31 are not wired out.
	assign gpio = pins[gpio_base +: 2];
	assign leds = pins[led_base +: $bits(led_t)];
	assign dac = pins[dac_base +: $bits(dac_t)];
	assign uart_tx = pins[uart_bit];
	assign vga.b = pins[vga_b_base +: 4];
	assign vga.r = pins[vga_r_base +: 4];
	assign vga.g = pins[vga_g_base +: 4];
	assign vga.hs = pins[hs_bit];
	assign vga.vs = pins[vs_bit];

endmodule

// ==== source/pin_bank.sv ====
module pin_bank
	import board_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 lane_we,
	input  logic [1:0]           lane_sel,
	input  logic [7:0]           lane_data,
	output logic [pin_width-1:0] pins,
	input  buttons_t             buttons,
	output buttons_t             buttons_sync
);

	buttons_t buttons_meta;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pins <= '0;
		else if (lane_we)
			pins[{lane_sel, 3'b000} +: 8] <= lane_data; // One byte lane per write.
	end

	// Buttons are asynchronous to clk.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			buttons_meta <= '0;
			buttons_sync <= '0;
		end
		else
		begin
			buttons_meta <= buttons;
			buttons_sync <= buttons_meta;
		end
	end

endmodule

// ==== source/por_reset.sv ====
module por_reset
	import script_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output logic core_rst_n
);

	logic [$bits(reset_hold)-1:0] hold_cnt;
	logic                         hold_done;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hold_cnt <= '0;
			hold_done <= 1'b0;
		end
		else
		begin
			if (hold_cnt != reset_hold)
				hold_cnt <= hold_cnt + 1'b1; // Saturates once the hold time is reached.
			hold_done <= (hold_cnt >= reset_hold - 1'b1);
		end
	end

	// The board reset reaches the core without waiting for a clock edge.
	assign core_rst_n = rst_n && hold_done;

endmodule

// ==== source/script_pkg.sv ====
package script_pkg;

	// First address fetched after reset.
	localparam logic [23:0] boot_addr = 24'h000000;

	// Core reset is held this many cycles after the board reset goes away.
	localparam logic [4:0] reset_hold = 5'd16;

	localparam logic [7:0] flash_read_cmd = 8'h03; // Plain read, no dummy cycles.

	// Flash deselects after this many idle cycles with no request.
	localparam logic [5:0] idle_release = 6'd48;

	typedef enum logic [7:0] {
		op_set_lane     = 8'h01,
		op_wait_buttons = 8'h02,
		op_delay        = 8'h03,
		op_jump         = 8'h04,
		op_halt         = 8'h05
	} opcode_t;

	// The opcode is the first byte in flash, arg_c the last.
	// set_lane: arg_a lane, arg_b data.
	// wait_buttons: arg_a mask, arg_b pattern.
	// delay: arg_b high count byte, arg_c low count byte.
	// jump: arg_a, arg_b, arg_c form the 24-bit target.
	typedef struct packed {
		opcode_t    opcode;
		logic [7:0] arg_a;
		logic [7:0] arg_b;
		logic [7:0] arg_c;
	} instr_t;

	typedef struct packed {
		logic        restart;
		logic [23:0] addr;
	} fetch_req_t;

endpackage

// ==== source/script_sequencer.sv ====
module script_sequencer
	import board_pkg::*, script_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	output logic       fetch_req,
	output fetch_req_t fetch_cmd,
	input  logic       fetch_ack,
	input  logic [7:0] fetch_data,
	output logic       lane_we,
	output logic [1:0] lane_sel,
	output logic [7:0] lane_data,
	input  buttons_t   buttons_sync
);

	typedef enum logic [2:0] {
		s_issue,
		s_fetch,
		s_exec,
		s_delay,
		s_wait_btn,
		s_halt
	} seq_state_t;

	seq_state_t  state;
	instr_t      instr;
	logic [1:0]  byte_cnt;
	logic [15:0] delay_cnt;
	logic        buttons_match;

	// Only buttons selected by the mask in arg_a are compared with arg_b.
	assign buttons_match = ((buttons_sync ^ instr.arg_b[$bits(buttons_t)-1:0])
		& instr.arg_a[$bits(buttons_t)-1:0]) == '0;

	assign lane_we = (state == s_exec) && (instr.opcode == op_set_lane);
	assign lane_sel = instr.arg_a[1:0];
	assign lane_data = instr.arg_b;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= s_issue;
			fetch_req <= 1'b0;
			fetch_cmd.restart <= 1'b1; // The first fetch opens a read at the boot address.
			fetch_cmd.addr <= boot_addr;
			byte_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				s_issue:
				begin
					// Four-phase handshake: the previous ack must be gone first.
					if (!fetch_ack)
					begin
						fetch_req <= 1'b1;
						state <= s_fetch;
					end
				end
				s_fetch:
				begin
					if (fetch_ack)
					begin
						fetch_req <= 1'b0;
						fetch_cmd.restart <= 1'b0;
						instr <= instr_t'({instr[23:0], fetch_data});
						byte_cnt <= byte_cnt + 1'b1;
						state <= (byte_cnt == 2'd3) ? s_exec : s_issue;
					end
				end
				s_exec:
				begin
					case (instr.opcode)
						op_set_lane:
							state <= s_issue;
						op_wait_buttons:
							state <= s_wait_btn;
						op_delay:
						begin
							delay_cnt <= {instr.arg_b, instr.arg_c};
							state <= s_delay;
						end
						op_jump:
						begin
							fetch_cmd.restart <= 1'b1;
							fetch_cmd.addr <= {instr.arg_a, instr.arg_b, instr.arg_c};
							state <= s_issue;
						end
						default:
							state <= s_halt;
					endcase
				end
				s_delay:
				begin
					if (delay_cnt == 16'd0)
						state <= s_issue;
					else
						delay_cnt <= delay_cnt - 1'b1;
				end
				s_wait_btn:
				begin
					if (buttons_match)
						state <= s_issue;
				end
				s_halt:
					state <= s_halt; // No more fetches until the next reset.
				default:
					state <= s_halt;
			endcase
		end
	end

	// Catches a script image holding a byte that is no opcode.
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == s_exec) |->
			(instr.opcode inside {op_set_lane, op_wait_buttons, op_delay, op_jump, op_halt}))
		else $error("Illegal opcode %h reached the decoder.", instr.opcode);

endmodule

// ==== source/spi_flash_reader.sv ====
module spi_flash_reader
	import script_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fetch_req,
	input  fetch_req_t fetch_cmd,
	output logic       fetch_ack,
	output logic [7:0] fetch_data,
	output logic       flash_cs_n,
	output logic       flash_sck,
	output logic       flash_mosi,
	input  logic       flash_miso
);

	typedef enum logic [2:0] {
		rd_idle,
		rd_command,
		rd_address,
		rd_data,
		rd_hand_off,
		rd_release
	} rd_state_t;

	rd_state_t                      state;
	logic [31:0]                    sh_out;  // Command byte and address, MSB first.
	logic [7:0]                     sh_in;
	logic [4:0]                     bit_cnt;
	logic [23:0]                    rd_addr; // Address of the next byte the flash returns.
	logic [$bits(idle_release)-1:0] idle_cnt;

	assign flash_mosi = sh_out[31];
	assign fetch_data = sh_in;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= rd_idle;
			fetch_ack <= 1'b0;
			flash_cs_n <= 1'b1;
			flash_sck <= 1'b0;
			sh_out <= '0;
			bit_cnt <= '0;
			rd_addr <= boot_addr;
			idle_cnt <= '0;
		end
		else
		begin
			case (state)
				rd_idle:
				begin
					if (fetch_req)
					begin
						idle_cnt <= '0;
						if (fetch_cmd.restart)
							rd_addr <= fetch_cmd.addr;
						// A closed flash needs the full command again, at the tracked address.
						if (fetch_cmd.restart || flash_cs_n)
						begin
							flash_cs_n <= 1'b1;
							state <= rd_release;
						end
						else
						begin
							bit_cnt <= 5'd7;
							state <= rd_data;
						end
					end
					else if (!flash_cs_n)
					begin
						if (idle_cnt == idle_release)
						begin
							flash_cs_n <= 1'b1;
							idle_cnt <= '0;
						end
						else
							idle_cnt <= idle_cnt + 1'b1;
					end
				end
				rd_release:
				begin
					flash_cs_n <= 1'b0;
					sh_out <= {flash_read_cmd, rd_addr};
					bit_cnt <= 5'd7;
					state <= rd_command;
				end
				rd_command, rd_address:
				begin
					flash_sck <= !flash_sck;
					if (flash_sck)
					begin
						sh_out <= {sh_out[30:0], 1'b0}; // Next bit goes out on the falling edge.
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == 5'd0)
						begin
							if (state == rd_command)
							begin
								bit_cnt <= 5'd23;
								state <= rd_address;
							end
							else
							begin
								bit_cnt <= 5'd7;
								state <= rd_data;
							end
						end
					end
				end
				rd_data:
				begin
					flash_sck <= !flash_sck;
					if (!flash_sck)
						sh_in <= {sh_in[6:0], flash_miso}; // Sample as SCK rises.
					else
					begin
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == 5'd0)
						begin
							rd_addr <= rd_addr + 1'b1;
							state <= rd_hand_off;
						end
					end
				end
				rd_hand_off:
				begin
					fetch_ack <= 1'b1;
					if (fetch_ack && !fetch_req)
					begin
						fetch_ack <= 1'b0;
						state <= rd_idle;
					end
				end
				default:
					state <= rd_idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) $rose(fetch_ack) |-> fetch_req)
		else $error("fetch_ack rose with no fetch_req pending.");

	assert property (@(posedge clk) disable iff (!rst_n) flash_cs_n |-> !flash_sck)
		else $error("flash_sck toggled while the flash was deselected.");

endmodule

// ==== testbench/script_golden.txt ====
# F lines hold a flash address and one instruction word, opcode byte first.
# S lines hold hold cycles, buttons, expected pins and least cycles since the last change.
F 000000 01000300
F 000004 0101a900
F 000008 02010100
F 00000c 01025a00
F 000010 03000200
F 000014 01033c00
F 000018 04000100
F 00001c 01031100
F 000100 01000200
F 000104 02030200
F 000108 01015600
F 00010c 05000000
F 000110 01020000
S 0 00 00000003 0
S 0 00 0000a903 0
S 200 01 005aa903 0
S 0 01 3c5aa903 512
S 0 01 3c5aa902 0
S 200 02 3c5a5602 0

// ==== testbench/spi_flash_model.sv ====
module spi_flash_model
(
	input  logic cs_n,
	input  logic sck,
	input  logic mosi,
	output logic miso
);

	timeunit 1ns;
	timeprecision 1ns;

	logic [7:0]  mem [0:4095]; // Image written by the testbench before reset ends.
	logic [31:0] header;
	logic [23:0] addr;
	logic [23:0] next_addr;    // Where a continuation read has to resume.
	logic [31:0] last_word;    // The four bytes delivered most recently.
	logic [2:0]  out_bit;
	int          hdr_bits;
	int          delivered;
	int          error_count;

	initial
	begin
		miso = 1'b0;
		header = '0;
		addr = '0;
		next_addr = 24'h000000;
		last_word = '0;
		out_bit = 3'd7;
		hdr_bits = 0;
		delivered = 0;
		error_count = 0;
	end

	// Reads start on instruction boundaries, so a jump shows up as the last whole word.
	task automatic start_read();
		logic [23:0] expected;
		if (delivered > 0 && delivered % 4 == 0 && last_word[31:24] == 8'h04)
			expected = last_word[23:0];
		else
			expected = next_addr;
		if (header[31:24] !== 8'h03)
		begin
			error_count++;
			$display("Error: flash_mosi command = %h, expected %h", header[31:24], 8'h03);
		end
		if (header[23:0] !== expected)
		begin
			error_count++;
			$display("Error: flash_mosi address = %h, expected %h", header[23:0], expected);
		end
		if (header[23:12] != 12'h000)
		begin
			error_count++;
			$display("The flash read address lies outside the loaded image.");
		end
		addr = header[23:0];
		out_bit = 3'd7;
	endtask

	always @(negedge cs_n)
		hdr_bits = 0;

	// Mode 0. Command and address come in on rising edges.
	always @(posedge sck)
	begin
		if (!cs_n && hdr_bits < 32)
		begin
			header = {header[30:0], mosi};
			hdr_bits = hdr_bits + 1;
			if (hdr_bits == 32)
				start_read();
		end
		else if (!cs_n)
		begin
			if (out_bit == 3'd0)
			begin
				last_word = {last_word[23:0], mem[addr[11:0]]};
				delivered++;
				addr = addr + 1'b1;
				next_addr = addr;
				out_bit = 3'd7;
			end
			else
				out_bit = out_bit - 1'b1;
		end
	end

	always @(negedge sck)
		if (!cs_n && hdr_bits == 32)
			miso = mem[addr[11:0]][out_bit]; // Data changes on falling edges.

endmodule

// ==== testbench/tb_board_top.sv ====
module tb_board_top
	import board_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int hold_cycles = 16;
	localparam int change_timeout = 5000;
	localparam int cs_timeout = 500;
	localparam int halt_window = 2000;

	typedef struct packed {
		logic [15:0] hold;    // Cycles the pins must stay put before the buttons change.
		logic [5:0]  buttons;
		logic [31:0] pins;
		logic [15:0] gap;     // Least cycles since the previous pin change.
	} step_t;

	logic     clk;
	logic     rst_n;
	buttons_t buttons;
	led_t     leds;
	vga_t     vga;
	dac_t     dac;
	logic     uart_tx;
	logic [1:0] gpio;
	logic     flash_cs_n;
	logic     flash_sck;
	logic     flash_mosi;
	logic     flash_miso;

	step_t steps[$];
	int    cyc;
	int    checks;
	int    errors;
	logic  aborted;

	board_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.buttons    (buttons),
		.leds       (leds),
		.vga        (vga),
		.dac        (dac),
		.uart_tx    (uart_tx),
		.gpio       (gpio),
		.flash_cs_n (flash_cs_n),
		.flash_sck  (flash_sck),
		.flash_mosi (flash_mosi),
		.flash_miso (flash_miso)
	);

	spi_flash_model i_flash (
		.cs_n (flash_cs_n),
		.sck  (flash_sck),
		.mosi (flash_mosi),
		.miso (flash_miso)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Inputs change and outputs are sampled 10 ns after the rising edge.
	task automatic next_cycle();
		@(posedge clk);
		#10;
		cyc++;
	endtask

	function automatic logic [31:0] pins_seen();
		logic [31:0] p;
		p = '0;
		p[gpio_base +: 2] = gpio;
		p[led_base +: 3] = leds;
		p[dac_base +: 4] = dac;
		p[uart_bit] = uart_tx;
		p[vga_b_base +: 4] = vga.b;
		p[vga_r_base +: 4] = vga.r;
		p[vga_g_base +: 4] = vga.g;
		p[hs_bit] = vga.hs;
		p[vs_bit] = vga.vs;
		return p;
	endfunction

	task automatic load_golden();
		int          fd;
		int          code;
		int          k;
		int          s_hold;
		int          s_gap;
		logic [63:0] kind;
		logic [959:0] rest;
		logic [23:0] f_addr;
		logic [31:0] f_word;
		logic [5:0]  s_btn;
		logic [31:0] s_pins;
		step_t       st;
		fd = $fopen("testbench/script_golden.txt", "r");
		if (fd == 0)
		begin
			errors++;
			aborted = 1'b1;
			$display("Could not open the golden file.");
			return;
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1)
				break;
			if (kind == "#")
				code = $fgets(rest, fd);
			else if (kind == "F")
			begin
				code = $fscanf(fd, "%h %h", f_addr, f_word);
				for (k = 0; k < 4; k++)
					i_flash.mem[f_addr[11:0] + k] = f_word[31 - 8 * k -: 8]; // Opcode first.
			end
			else if (kind == "S")
			begin
				code = $fscanf(fd, "%d %h %h %d", s_hold, s_btn, s_pins, s_gap);
				st.hold = s_hold;
				st.buttons = s_btn;
				st.pins = s_pins;
				st.gap = s_gap;
				steps.push_back(st);
			end
			else
			begin
				errors++;
				$display("The golden file holds a record of unknown kind.");
			end
		end
		$fclose(fd);
		if (steps.size() == 0)
		begin
			errors++;
			aborted = 1'b1;
			$display("The golden file holds no script steps.");
		end
	endtask

	task automatic check_idle_outputs();
		checks++;
		if (pins_seen() !== 32'h0 || flash_cs_n !== 1'b1 || flash_sck !== 1'b0
			|| flash_mosi !== 1'b0)
		begin
			errors++;
			$display("Error: pins = %h, flash_cs_n = %h, flash_sck = %h, flash_mosi = %h",
				pins_seen(), flash_cs_n, flash_sck, flash_mosi);
			$display("Error: expected pins = 0, flash_cs_n = 1, flash_sck = 0, flash_mosi = 0");
		end
	endtask

	task automatic check_reset();
		int i;
		for (i = 0; i < 8; i++)
		begin
			next_cycle();
			check_idle_outputs();
		end
		rst_n = 1'b1;
		for (i = 0; i < hold_cycles; i++)
		begin
			next_cycle();
			check_idle_outputs();
		end
	endtask

	task automatic run_steps();
		step_t       st;
		logic [31:0] prev;
		logic [31:0] now;
		logic        bad;
		int          last_change;
		int          n;
		prev = '0;
		last_change = cyc;
		foreach (steps[k])
		begin
			st = steps[k];
			bad = 1'b0;
			for (n = 0; n < st.hold && !bad; n++)
			begin
				next_cycle();
				checks++;
				if (pins_seen() !== prev)
				begin
					errors++;
					bad = 1'b1;
					$display("Error: pins = %h before buttons %h were driven, expected %h",
						pins_seen(), st.buttons, prev);
				end
			end
			buttons = st.buttons;
			n = 0;
			while (pins_seen() === prev && n < change_timeout)
			begin
				next_cycle();
				n++;
			end
			if (pins_seen() === prev)
			begin
				errors++;
				aborted = 1'b1;
				$display("Timeout: the pins never moved on from %h.", prev);
				return;
			end
			now = pins_seen();
			checks++;
			if (now !== st.pins)
			begin
				errors++;
				$display("Error: pins = %h, expected %h", now, st.pins);
			end
			if (cyc - last_change < st.gap)
			begin
				errors++;
				$display("Error: pin change gap = %h cycles, expected at least %h",
					cyc - last_change, st.gap);
			end
			prev = now;
			last_change = cyc;
		end
	endtask

	task automatic check_halt();
		logic [31:0] held;
		logic        bad;
		int          n;
		held = pins_seen();
		n = 0;
		while (flash_cs_n !== 1'b1 && n < cs_timeout)
		begin
			next_cycle();
			n++;
		end
		if (flash_cs_n !== 1'b1)
		begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: the flash was never deselected after the halt.");
			return;
		end
		bad = 1'b0;
		for (n = 0; n < halt_window && !bad; n++)
		begin
			next_cycle();
			checks++;
			if (pins_seen() !== held || flash_cs_n !== 1'b1)
			begin
				errors++;
				bad = 1'b1;
				$display("Error: pins = %h, flash_cs_n = %h after halt, expected %h, 1",
					pins_seen(), flash_cs_n, held);
			end
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		buttons = '0;
		cyc = 0;
		checks = 0;
		errors = 0;
		aborted = 1'b0;
		load_golden();
		if (!aborted)
			check_reset();
		if (!aborted)
			run_steps();
		if (!aborted)
			check_halt();
		$display("Checks: %0d, errors: %0d, flash model errors: %0d",
			checks, errors, i_flash.error_count);
		if (errors == 0 && i_flash.error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
